//--- include/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 32
`define SOC_BE_W   4

// Region codes, address bits 31:28
`define SOC_REGION_L2   4'h8
`define SOC_REGION_UART 4'hC
`define SOC_REGION_CTRL 4'hD

`define SOC_L2_WORDS 256

`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h4000_0000

// Control register word indices
`define SOC_CTRL_EXIT      3'd0
`define SOC_CTRL_CNT_EN    3'd1
`define SOC_CTRL_DRAM_BASE 3'd2
`define SOC_CTRL_DRAM_LEN  3'd3

`endif

//--- rtl/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // Region code on top, offset inside the region below
  typedef struct packed {
    logic [3:0]             region;
    logic [`SOC_ADDR_W-5:0] offset;
  } soc_addr_fields_t;

  // Full address or region/offset view of the same word
  typedef union packed {
    logic [`SOC_ADDR_W-1:0] raw;
    soc_addr_fields_t       fields;
  } soc_addr_u;

endpackage

//--- rtl/periph_if.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

interface periph_if;
  import soc_pkg::*;

  logic                   req;
  logic                   we;
  soc_addr_u              addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_BE_W-1:0]   be;
  logic                   ack;
  logic [`SOC_DATA_W-1:0] rdata;
  logic                   err;

  modport requester (
    output req, we, addr, wdata, be,
    input  ack, rdata, err
  );

  modport target (
    input  req, we, addr, wdata, be,
    output ack, rdata, err
  );

endinterface

//--- rtl/soc_addr_decoder.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_addr_decoder (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  soc_pkg::soc_addr_u     host_addr_i,
  input  logic [`SOC_DATA_W-1:0] host_wdata_i,
  input  logic [`SOC_BE_W-1:0]   host_be_i,
  output logic                   host_ack_o,
  output logic                   host_err_o,
  output logic [`SOC_DATA_W-1:0] host_rdata_o,
  periph_if.requester            l2_o,
  periph_if.requester            uart_o,
  periph_if.requester            ctrl_o
);
  import soc_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_DRAIN, ST_ERR} state_e;
  typedef enum logic [1:0] {SEL_L2, SEL_UART, SEL_CTRL, SEL_NONE} sel_e;

  state_e                 state_q;
  sel_e                   sel_q;
  sel_e                   sel_d;
  logic                   we_q;
  soc_addr_u              addr_q;
  logic [`SOC_DATA_W-1:0] wdata_q;
  logic [`SOC_BE_W-1:0]   be_q;
  logic                   ack_q;
  logic                   err_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   tgt_ack;
  logic                   tgt_err;
  logic [`SOC_DATA_W-1:0] tgt_rdata;

  //////////////////////////////////////////////////
  // Region decode and target mux
  //////////////////////////////////////////////////

  always_comb begin
    case (host_addr_i.fields.region)
      `SOC_REGION_L2:   sel_d = SEL_L2;
      `SOC_REGION_UART: sel_d = SEL_UART;
      `SOC_REGION_CTRL: sel_d = SEL_CTRL;
      default:          sel_d = SEL_NONE;
    endcase
  end

  always_comb begin
    case (sel_q)
      SEL_L2: begin
        tgt_ack   = l2_o.ack;
        tgt_err   = l2_o.err;
        tgt_rdata = l2_o.rdata;
      end
      SEL_UART: begin
        tgt_ack   = uart_o.ack;
        tgt_err   = uart_o.err;
        tgt_rdata = uart_o.rdata;
      end
      SEL_CTRL: begin
        tgt_ack   = ctrl_o.ack;
        tgt_err   = ctrl_o.err;
        tgt_rdata = ctrl_o.rdata;
      end
      default: begin
        tgt_ack   = 1'b0;
        tgt_err   = 1'b1;
        tgt_rdata = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Host handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      sel_q   <= SEL_NONE;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (host_req_i) begin
            sel_q   <= sel_d;
            state_q <= (sel_d == SEL_NONE) ? ST_ERR : ST_FWD;
          end
        end
        ST_FWD: begin
          if (tgt_ack) begin
            ack_q   <= 1'b1;
            err_q   <= tgt_err;
            state_q <= ST_DRAIN;
          end
        end
        ST_ERR: begin
          ack_q   <= 1'b1;
          err_q   <= 1'b1;
          state_q <= ST_DRAIN;
        end
        default: begin
          // Link req is already low here, close both sides together
          if (!tgt_ack && !host_req_i) begin
            ack_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Host fields and response data
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && host_req_i) begin
      we_q    <= host_we_i;
      addr_q  <= host_addr_i;
      wdata_q <= host_wdata_i;
      be_q    <= host_be_i;
    end
    if (state_q == ST_FWD && tgt_ack) begin
      rdata_q <= tgt_rdata;
    end else if (state_q == ST_ERR) begin
      rdata_q <= '0;
    end
  end

  assign host_ack_o   = ack_q;
  assign host_err_o   = err_q;
  assign host_rdata_o = rdata_q;

  // Fields go to every link, req to the selected one only
  assign l2_o.req   = (state_q == ST_FWD) && (sel_q == SEL_L2);
  assign l2_o.we    = we_q;
  assign l2_o.addr  = addr_q;
  assign l2_o.wdata = wdata_q;
  assign l2_o.be    = be_q;

  assign uart_o.req   = (state_q == ST_FWD) && (sel_q == SEL_UART);
  assign uart_o.we    = we_q;
  assign uart_o.addr  = addr_q;
  assign uart_o.wdata = wdata_q;
  assign uart_o.be    = be_q;

  assign ctrl_o.req   = (state_q == ST_FWD) && (sel_q == SEL_CTRL);
  assign ctrl_o.we    = we_q;
  assign ctrl_o.addr  = addr_q;
  assign ctrl_o.wdata = wdata_q;
  assign ctrl_o.be    = be_q;

endmodule

//--- rtl/l2_mem.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module l2_mem (
  input  logic      clk_i,
  input  logic      rst_i,
  periph_if.target  bus_i
);

  localparam int IDX_W = $clog2(`SOC_L2_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_L2_WORDS];
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]       word_idx;
  logic                   rd_q;
  logic                   ack_q;
  logic                   start;

  // Byte offset dropped, upper bits alias
  assign word_idx = bus_i.addr.raw[IDX_W+1:2];
  assign start    = bus_i.req && !rd_q && !ack_q;

  always_ff @(posedge clk_i) begin
    if (start) begin
      if (bus_i.we) begin
        for (int b = 0; b < `SOC_BE_W; b++) begin
          if (bus_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // Access cycle, then ack until req drops
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_q  <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      rd_q <= start;
      if (rd_q) begin
        ack_q <= 1'b1;
      end else if (!bus_i.req) begin
        ack_q <= 1'b0;
      end
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.rdata = rdata_q;
  assign bus_i.err   = 1'b0;

endmodule

//--- rtl/uart_apb_bridge.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module uart_apb_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  periph_if.target               bus_i,
  output logic                   psel_o,
  output logic                   penable_o,
  output logic                   pwrite_o,
  output logic [`SOC_ADDR_W-1:0] paddr_o,
  output logic [`SOC_DATA_W-1:0] pwdata_o,
  input  logic [`SOC_DATA_W-1:0] prdata_i,
  input  logic                   pready_i,
  input  logic                   pslverr_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_RESP} state_e;

  state_e                 state_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   err_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (bus_i.req) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: state_q <= ST_ACCESS;
        ST_ACCESS: begin
          // Completer may stretch this phase
          if (pready_i) begin
            state_q <= ST_RESP;
          end
        end
        default: begin
          if (!bus_i.req) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Response sampled at the completing access cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ST_ACCESS && pready_i) begin
      rdata_q <= bus_i.we ? '0 : prdata_i;
      err_q   <= pslverr_i;
    end
  end

  assign psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign penable_o = (state_q == ST_ACCESS);
  assign pwrite_o  = bus_i.we;
  assign paddr_o   = bus_i.addr.raw;
  assign pwdata_o  = bus_i.wdata;

  assign bus_i.ack   = (state_q == ST_RESP);
  assign bus_i.rdata = rdata_q;
  assign bus_i.err   = err_q;

endmodule

//--- rtl/ctrl_regs.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  periph_if.target               bus_i,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);

  logic [2:0]             reg_idx;
  logic                   start;
  logic                   ack_q;
  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] cnt_en_q;
  logic [`SOC_DATA_W-1:0] rd_val;
  logic [`SOC_DATA_W-1:0] rdata_q;

  assign reg_idx = bus_i.addr.fields.offset[4:2];
  assign start   = bus_i.req && !ack_q;

  always_comb begin
    case (reg_idx)
      `SOC_CTRL_EXIT:      rd_val = exit_q;
      `SOC_CTRL_CNT_EN:    rd_val = cnt_en_q;
      `SOC_CTRL_DRAM_BASE: rd_val = `SOC_DRAM_BASE;
      `SOC_CTRL_DRAM_LEN:  rd_val = `SOC_DRAM_LEN;
      default:             rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else begin
      if (start) begin
        ack_q <= 1'b1;
        if (bus_i.we) begin
          for (int b = 0; b < `SOC_BE_W; b++) begin
            if (bus_i.be[b] && reg_idx == `SOC_CTRL_EXIT) begin
              exit_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
            end
            if (bus_i.be[b] && reg_idx == `SOC_CTRL_CNT_EN) begin
              cnt_en_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
            end
          end
        end
      end else if (!bus_i.req) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    if (start) begin
      rdata_q <= bus_i.we ? '0 : rd_val;
    end
  end

  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

  assign bus_i.ack   = ack_q;
  assign bus_i.rdata = rdata_q;
  assign bus_i.err   = 1'b0;

endmodule

//--- rtl/soc_top.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`SOC_ADDR_W-1:0] addr_i,
  input  logic [`SOC_DATA_W-1:0] wdata_i,
  input  logic [`SOC_BE_W-1:0]   be_i,
  output logic                   ack_o,
  output logic                   err_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`SOC_DATA_W-1:0] uart_pwdata_o,
  input  logic [`SOC_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);
  import soc_pkg::*;

  periph_if l2_link ();
  periph_if uart_link ();
  periph_if ctrl_link ();

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  soc_addr_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host_req_i  (req_i),
    .host_we_i   (we_i),
    .host_addr_i (soc_addr_u'(addr_i)),
    .host_wdata_i(wdata_i),
    .host_be_i   (be_i),
    .host_ack_o  (ack_o),
    .host_err_o  (err_o),
    .host_rdata_o(rdata_o),
    .l2_o        (l2_link),
    .uart_o      (uart_link),
    .ctrl_o      (ctrl_link)
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  l2_mem i_l2 (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .bus_i(l2_link)
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus_i    (uart_link),
    .psel_o   (uart_psel_o),
    .penable_o(uart_penable_o),
    .pwrite_o (uart_pwrite_o),
    .paddr_o  (uart_paddr_o),
    .pwdata_o (uart_pwdata_o),
    .prdata_i (uart_prdata_i),
    .pready_i (uart_pready_i),
    .pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus_i      (ctrl_link),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

//--- bench/soc_assert.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_assert (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   req_i,
  input logic                   ack_o,
  input logic                   uart_psel_o,
  input logic                   uart_penable_o,
  input logic [`SOC_ADDR_W-1:0] uart_paddr_o
);

  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // Host four-phase handshake
  //////////////////////////////////////////////////

  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_o) |-> req_i)
    else begin
      $error("ack_o rose without req_i");
      fail_cnt++;
    end

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(ack_o) |-> $past(!req_i))
    else begin
      $error("ack_o fell while req_i was still high");
      fail_cnt++;
    end

  //////////////////////////////////////////////////
  // APB requester side
  //////////////////////////////////////////////////

  // One setup cycle, then penable with psel still high
  setup_then_access: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(uart_psel_o) |-> !uart_penable_o ##1 (uart_psel_o && uart_penable_o))
    else begin
      $error("uart_penable_o did not follow a single setup cycle under uart_psel_o");
      fail_cnt++;
    end

  paddr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (uart_psel_o && $past(uart_psel_o)) |-> $stable(uart_paddr_o))
    else begin
      $error("uart_paddr_o changed during an APB transfer");
      fail_cnt++;
    end

endmodule

bind soc_top soc_assert i_soc_assert (.*);

//--- bench/soc_tb.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_tb;
  import soc_pkg::*;

  localparam int NUM_ROWS   = 21;
  localparam int RST_CYCLES = 4;
  localparam int MAX_CYCLES = 40 * NUM_ROWS + RST_CYCLES;

  typedef struct packed {
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] exp_rdata;
    logic                   exp_err;
    logic [`SOC_DATA_W-1:0] exp_exit;
    logic [`SOC_DATA_W-1:0] exp_cnt;
  } row_t;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_i;
  logic                   we_i;
  logic [`SOC_ADDR_W-1:0] addr_i;
  logic [`SOC_DATA_W-1:0] wdata_i;
  logic [`SOC_BE_W-1:0]   be_i;
  logic                   ack_o;
  logic                   err_o;
  logic [`SOC_DATA_W-1:0] rdata_o;
  logic [`SOC_DATA_W-1:0] exit_o;
  logic [`SOC_DATA_W-1:0] hw_cnt_en_o;
  logic                   uart_psel_o;
  logic                   uart_penable_o;
  logic                   uart_pwrite_o;
  logic [`SOC_ADDR_W-1:0] uart_paddr_o;
  logic [`SOC_DATA_W-1:0] uart_pwdata_o;
  logic [`SOC_DATA_W-1:0] uart_prdata_i;
  logic                   uart_pready_i;
  logic                   uart_pslverr_i;

  row_t                   rows [NUM_ROWS];
  logic [31:0]            lcg_state = 32'h2b4a;
  int                     wait_cnt;
  int                     cycle_cnt;
  int                     err_cnt;
  int                     bad_tests;
  logic                   test_bad;
  logic                   last_pwrite;
  logic [`SOC_ADDR_W-1:0] last_paddr;
  logic [`SOC_DATA_W-1:0] last_pwdata;

  soc_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic row_t make_row(input logic we, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [3:0] be,
                                    input logic [31:0] exp_rdata, input logic exp_err,
                                    input logic [31:0] exp_exit, input logic [31:0] exp_cnt);
    row_t r;
    r = {we, addr, wdata, be, exp_rdata, exp_err, exp_exit, exp_cnt};
    return r;
  endfunction

  //////////////////////////////////////////////////
  // APB completer model
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_i) begin
      uart_pready_i <= 1'b0;
      wait_cnt      <= 0;
    end else if (uart_psel_o && uart_penable_o && !uart_pready_i) begin
      if (wait_cnt == 0) begin
        uart_pready_i  <= 1'b1;
        uart_prdata_i  <= uart_paddr_o ^ 32'hA5A5_0000;
        uart_pslverr_i <= uart_paddr_o[11];
        last_pwrite    <= uart_pwrite_o;
        last_paddr     <= uart_paddr_o;
        last_pwdata    <= uart_pwdata_o;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else begin
      uart_pready_i <= 1'b0;
      // Pick the stall length in the setup phase
      if (uart_psel_o && !uart_penable_o) begin
        wait_cnt <= int'(lcg_next() >> 16) % 4;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the DUT did not finish the transfers within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Host driver and checks
  //////////////////////////////////////////////////

  task automatic host_transfer(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                               input logic [`SOC_DATA_W-1:0] wdata,
                               input logic [`SOC_BE_W-1:0] be,
                               output logic [`SOC_DATA_W-1:0] rdata, output logic err);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    be_i    <= be;
    do @(posedge clk_i); while (!ack_o);
    rdata = rdata_o;
    err   = err_o;
    req_i <= 1'b0;
    do @(posedge clk_i); while (ack_o);
  endtask

  task automatic check_word(input string what, input logic [`SOC_DATA_W-1:0] got,
                            input logic [`SOC_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
      test_bad = 1'b1;
    end
  endtask

  task automatic report_test(input int num, input string label);
    $display("test %0d %s: %s", num, label, test_bad ? "FAIL" : "ok");
    if (test_bad) begin
      bad_tests++;
    end
  endtask

  initial begin
    logic [`SOC_DATA_W-1:0] got_rdata;
    logic                   got_err;
    soc_addr_u              addr_view;

    rst_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    uart_prdata_i = '0;
    uart_pready_i = 1'b0;
    uart_pslverr_i = 1'b0;
    cycle_cnt = 0;
    err_cnt = 0;
    bad_tests = 0;

    // L2 byte merge and aliasing
    rows[0]  = make_row(1, 32'h8000_0010, 32'h1122_3344, 4'hF, 32'h0, 0, 32'h0, 32'h0);
    rows[1]  = make_row(1, 32'h8000_0010, 32'hAABB_CCDD, 4'h5, 32'h0, 0, 32'h0, 32'h0);
    rows[2]  = make_row(0, 32'h8000_0010, 32'h0, 4'hF, 32'h11BB_33DD, 0, 32'h0, 32'h0);
    // Word 0 is also where an unmapped write would land
    rows[3]  = make_row(1, 32'h8000_0000, 32'hDEAD_BEEF, 4'hF, 32'h0, 0, 32'h0, 32'h0);
    rows[4]  = make_row(0, 32'h8000_0400, 32'h0, 4'hF, 32'hDEAD_BEEF, 0, 32'h0, 32'h0);
    // Control registers
    rows[5]  = make_row(1, 32'hD000_0000, 32'h0000_0001, 4'hF, 32'h0, 0, 32'h1, 32'h0);
    rows[6]  = make_row(1, 32'hD000_0004, 32'h1234_5678, 4'h3, 32'h0, 0, 32'h1, 32'h5678);
    rows[7]  = make_row(0, 32'hD000_0004, 32'h0, 4'hF, 32'h5678, 0, 32'h1, 32'h5678);
    rows[8]  = make_row(0, 32'hD000_0008, 32'h0, 4'hF, 32'h8000_0000, 0, 32'h1, 32'h5678);
    rows[9]  = make_row(0, 32'hD000_000C, 32'h0, 4'hF, 32'h4000_0000, 0, 32'h1, 32'h5678);
    rows[10] = make_row(1, 32'hD000_0008, 32'hFFFF_FFFF, 4'hF, 32'h0, 0, 32'h1, 32'h5678);
    rows[11] = make_row(0, 32'hD000_0008, 32'h0, 4'hF, 32'h8000_0000, 0, 32'h1, 32'h5678);
    rows[12] = make_row(0, 32'hD000_0010, 32'h0, 4'hF, 32'h0, 0, 32'h1, 32'h5678);
    // UART over APB, bit 11 gives pslverr
    rows[13] = make_row(0, 32'hC000_0100, 32'h0, 4'hF, 32'h65A5_0100, 0, 32'h1, 32'h5678);
    rows[14] = make_row(1, 32'hC000_0204, 32'h0000_0041, 4'hF, 32'h0, 0, 32'h1, 32'h5678);
    rows[15] = make_row(0, 32'hC000_0800, 32'h0, 4'hF, 32'h65A5_0800, 1, 32'h1, 32'h5678);
    // Unmapped regions, then read-back
    rows[16] = make_row(1, 32'h0000_1000, 32'hFFFF_FFFF, 4'hF, 32'h0, 1, 32'h1, 32'h5678);
    rows[17] = make_row(1, 32'hF000_0000, 32'hFFFF_FFFF, 4'hF, 32'h0, 1, 32'h1, 32'h5678);
    rows[18] = make_row(0, 32'h0000_1000, 32'h0, 4'hF, 32'h0, 1, 32'h1, 32'h5678);
    rows[19] = make_row(0, 32'h8000_0000, 32'h0, 4'hF, 32'hDEAD_BEEF, 0, 32'h1, 32'h5678);
    rows[20] = make_row(0, 32'hD000_0000, 32'h0, 4'hF, 32'h1, 0, 32'h1, 32'h5678);

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    test_bad = 1'b0;
    check_word("exit_o", exit_o, '0);
    check_word("hw_cnt_en_o", hw_cnt_en_o, '0);
    check_flag("ack_o", ack_o, 1'b0);
    check_flag("uart_psel_o", uart_psel_o, 1'b0);
    check_flag("uart_penable_o", uart_penable_o, 1'b0);
    report_test(0, "reset state");

    for (int i = 0; i < NUM_ROWS; i++) begin
      test_bad = 1'b0;
      host_transfer(rows[i].we, rows[i].addr, rows[i].wdata, rows[i].be, got_rdata, got_err);
      check_word("rdata_o", got_rdata, rows[i].exp_rdata);
      check_flag("err_o", got_err, rows[i].exp_err);
      check_word("exit_o", exit_o, rows[i].exp_exit);
      check_word("hw_cnt_en_o", hw_cnt_en_o, rows[i].exp_cnt);
      addr_view = rows[i].addr;
      if (addr_view.fields.region == `SOC_REGION_UART) begin
        check_flag("uart_pwrite_o", last_pwrite, rows[i].we);
        check_word("uart_paddr_o", last_paddr, rows[i].addr);
        if (rows[i].we) begin
          check_word("uart_pwdata_o", last_pwdata, rows[i].wdata);
        end
      end
      report_test(i + 1, $sformatf("%s %h", rows[i].we ? "write" : "read", rows[i].addr));
    end

    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures", NUM_ROWS + 1,
             bad_tests, err_cnt, UUT.i_soc_assert.fail_cnt);
    if (err_cnt == 0 && UUT.i_soc_assert.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
rtl/soc_pkg.sv
rtl/periph_if.sv
rtl/soc_addr_decoder.sv
rtl/l2_mem.sv
rtl/uart_apb_bridge.sv
rtl/ctrl_regs.sv
rtl/soc_top.sv
bench/soc_assert.sv
bench/soc_tb.sv
